/* bench/axil_mem_patterns.txt */
# op port addr data strb resp expdata  (hex; op W write, R read, A paired read)
# A lines come in pairs issued together, listed in the expected serving order
W 1 000 1111111111111111 ff 0 0000000000000000
W 1 008 2222222222222222 ff 0 0000000000000000
W 1 010 3333333333333333 ff 0 0000000000000000
W 1 018 4444444444444444 ff 0 0000000000000000
W 1 7f8 5555555555555555 ff 0 0000000000000000
A 0 000 0000000000000000 00 0 1111111111111111
A 1 008 0000000000000000 00 0 2222222222222222
A 0 010 0000000000000000 00 0 3333333333333333
A 1 018 0000000000000000 00 0 4444444444444444
R 0 7f8 0000000000000000 00 0 5555555555555555
A 1 000 0000000000000000 00 0 1111111111111111
A 0 008 0000000000000000 00 0 2222222222222222
W 1 008 aabbccddeeff0011 0f 0 0000000000000000
R 0 008 0000000000000000 00 0 22222222eeff0011
R 1 008 0000000000000000 00 0 22222222eeff0011
W 1 010 9988776655443322 a5 0 0000000000000000
R 1 010 0000000000000000 00 0 9933773333443322
R 0 010 0000000000000000 00 0 9933773333443322
W 1 800 deadbeefdeadbeef ff 2 0000000000000000
R 1 800 0000000000000000 00 2 0000000000000000
R 0 000 0000000000000000 00 0 1111111111111111
W 1 1008 cafef00dcafef00d ff 2 0000000000000000
R 0 1008 0000000000000000 00 2 0000000000000000
R 1 000 0000000000000000 00 0 1111111111111111
A 0 018 0000000000000000 00 0 4444444444444444
A 1 7f8 0000000000000000 00 0 5555555555555555
W 1 018 0123456789abcdef ff 0 0000000000000000
W 1 020 fedcba9876543210 ff 0 0000000000000000
R 1 018 0000000000000000 00 0 0123456789abcdef
R 0 020 0000000000000000 00 0 fedcba9876543210
A 1 020 0000000000000000 00 0 fedcba9876543210
A 0 018 0000000000000000 00 0 0123456789abcdef

/* bench/axil_mem_props.sv */
// Memory subsystem channel checks
`timescale 1ns/1ns

module axil_mem_props
  import axil_mem_pkg::*;
#(
  parameter int DATA_WIDTH = AXIL_DATA_WIDTH_DEF
) (
  input logic                  i_aclk,
  input logic                  i_rst_n,
  input logic                  i_m0_arvalid,
  input logic                  o_m0_arready,
  input logic                  o_m0_rvalid,
  input logic                  i_m0_rready,
  input logic [DATA_WIDTH-1:0] o_m0_rdata,
  input axil_resp_e            o_m0_rresp,
  input logic                  i_m1_arvalid,
  input logic                  o_m1_arready,
  input logic                  o_m1_rvalid,
  input logic                  i_m1_rready,
  input logic [DATA_WIDTH-1:0] o_m1_rdata,
  input axil_resp_e            o_m1_rresp,
  input logic                  o_m1_wready,
  input logic                  o_m1_bvalid,
  input logic                  i_m1_bready,
  input axil_resp_e            o_m1_bresp
);

  axil_grant_e owner;
  logic        in_flight;

  // ----------------------------------------------------------------------
  // Read data channels hold until their handshake
  // ----------------------------------------------------------------------
  m0_r_stable: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    o_m0_rvalid && !i_m0_rready |=> o_m0_rvalid && $stable(o_m0_rdata) && $stable(o_m0_rresp))
    else $error("port 0 read data changed before its handshake");

  m1_r_stable: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    o_m1_rvalid && !i_m1_rready |=> o_m1_rvalid && $stable(o_m1_rdata) && $stable(o_m1_rresp))
    else $error("port 1 read data changed before its handshake");

  // Write response
  b_stable: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    o_m1_bvalid && !i_m1_bready |=> o_m1_bvalid && $stable(o_m1_bresp))
    else $error("write response changed before its handshake");

  // ----------------------------------------------------------------------
  // Reset and grant rules
  // ----------------------------------------------------------------------
  reset_quiet: assert property (@(posedge i_aclk)
    !i_rst_n |=> !o_m0_rvalid && !o_m1_rvalid && !o_m1_bvalid && !o_m1_wready)
    else $error("valid or wready high after reset");

  // Outstanding read, rebuilt from the port handshakes
  always_ff @(posedge i_aclk) begin
    if (!i_rst_n) begin
      in_flight <= 1'b0;
      owner     <= GRANT_FETCH;
    end else if (!in_flight) begin
      if (i_m0_arvalid && o_m0_arready) begin
        in_flight <= 1'b1;
        owner     <= GRANT_FETCH;
      end else if (i_m1_arvalid && o_m1_arready) begin
        in_flight <= 1'b1;
        owner     <= GRANT_DATA;
      end
    end else if ((o_m0_rvalid && i_m0_rready) || (o_m1_rvalid && i_m1_rready)) begin
      in_flight <= 1'b0;
    end
  end

  busy_no_ready: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    in_flight |-> !o_m0_arready && !o_m1_arready)
    else $error("arready high while a read grant is busy");

  // Only the granted master may see read data
  m0_rvalid_owner: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    o_m0_rvalid |-> in_flight && (owner == GRANT_FETCH))
    else $error("port 0 read data without a port 0 grant");

  m1_rvalid_owner: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    o_m1_rvalid |-> in_flight && (owner == GRANT_DATA))
    else $error("port 1 read data without a port 1 grant");

endmodule

bind axil_mem_top axil_mem_props #(.DATA_WIDTH(DATA_WIDTH)) u_props (
  .i_aclk       (i_aclk),
  .i_rst_n      (i_rst_n),
  .i_m0_arvalid (i_m0_arvalid),
  .o_m0_arready (o_m0_arready),
  .o_m0_rvalid  (o_m0_rvalid),
  .i_m0_rready  (i_m0_rready),
  .o_m0_rdata   (o_m0_rdata),
  .o_m0_rresp   (o_m0_rresp),
  .i_m1_arvalid (i_m1_arvalid),
  .o_m1_arready (o_m1_arready),
  .o_m1_rvalid  (o_m1_rvalid),
  .i_m1_rready  (i_m1_rready),
  .o_m1_rdata   (o_m1_rdata),
  .o_m1_rresp   (o_m1_rresp),
  .o_m1_wready  (o_m1_wready),
  .o_m1_bvalid  (o_m1_bvalid),
  .i_m1_bready  (i_m1_bready),
  .o_m1_bresp   (o_m1_bresp)
);

/* bench/tb_axil_mem.sv */
// Memory subsystem testbench
`timescale 1ns/1ns

module tb_axil_mem
  import axil_mem_pkg::*;
;

  localparam int ADDR_WIDTH = AXIL_ADDR_WIDTH_DEF;
  localparam int DATA_WIDTH = AXIL_DATA_WIDTH_DEF;
  localparam int MEM_DEPTH  = AXIL_MEM_DEPTH_DEF;
  localparam int STRB_WIDTH = DATA_WIDTH / 8;
  localparam int MAX_STALL  = 4;

  logic                  clk;
  logic                  rst_n;
  logic                  m0_arvalid, m0_arready, m0_rvalid, m0_rready;
  logic [ADDR_WIDTH-1:0] m0_araddr;
  logic [DATA_WIDTH-1:0] m0_rdata;
  axil_resp_e            m0_rresp;
  logic                  m1_awvalid, m1_awready, m1_wvalid, m1_wready;
  logic [ADDR_WIDTH-1:0] m1_awaddr, m1_araddr;
  logic [DATA_WIDTH-1:0] m1_wdata, m1_rdata;
  logic [STRB_WIDTH-1:0] m1_wstrb;
  logic                  m1_bvalid, m1_bready, m1_arvalid, m1_arready, m1_rvalid, m1_rready;
  axil_resp_e            m1_bresp, m1_rresp;

  // Pattern table
  byte                   pat_op[$];
  int                    pat_port[$];
  logic [ADDR_WIDTH-1:0] pat_addr[$];
  logic [DATA_WIDTH-1:0] pat_data[$];
  logic [STRB_WIDTH-1:0] pat_strb[$];
  axil_resp_e            pat_resp[$];
  logic [DATA_WIDTH-1:0] pat_exp[$];

  logic [DATA_WIDTH-1:0] ref_mem [int];
  axil_grant_e           served[$];
  int                    seed = 32'he92b_2b2e;
  int                    wd_limit = 0;

  axil_mem_top #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .DATA_WIDTH (DATA_WIDTH),
    .MEM_DEPTH  (MEM_DEPTH)
  ) uut (
    .i_aclk       (clk),
    .i_rst_n      (rst_n),
    .i_m0_arvalid (m0_arvalid),
    .o_m0_arready (m0_arready),
    .i_m0_araddr  (m0_araddr),
    .o_m0_rvalid  (m0_rvalid),
    .i_m0_rready  (m0_rready),
    .o_m0_rdata   (m0_rdata),
    .o_m0_rresp   (m0_rresp),
    .i_m1_awvalid (m1_awvalid),
    .o_m1_awready (m1_awready),
    .i_m1_awaddr  (m1_awaddr),
    .i_m1_wvalid  (m1_wvalid),
    .o_m1_wready  (m1_wready),
    .i_m1_wdata   (m1_wdata),
    .i_m1_wstrb   (m1_wstrb),
    .o_m1_bvalid  (m1_bvalid),
    .i_m1_bready  (m1_bready),
    .o_m1_bresp   (m1_bresp),
    .i_m1_arvalid (m1_arvalid),
    .o_m1_arready (m1_arready),
    .i_m1_araddr  (m1_araddr),
    .o_m1_rvalid  (m1_rvalid),
    .i_m1_rready  (m1_rready),
    .o_m1_rdata   (m1_rdata),
    .o_m1_rresp   (m1_rresp)
  );

  always #50 clk = ~clk;

  // ----------------------------------------------------------------------
  // Failure reporting and compare tasks
  // ----------------------------------------------------------------------
  task automatic abort_run(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input logic [DATA_WIDTH-1:0] act,
                            input logic [DATA_WIDTH-1:0] exp);
    if (act !== exp)
      abort_run($sformatf("Mismatch at %0t ns: %s got %h expected %h", $time, name, act, exp));
  endtask

  task automatic check_resp(input string name, input axil_resp_e act, input axil_resp_e exp);
    if (act !== exp)
      abort_run($sformatf("Mismatch at %0t ns: %s got %s expected %s",
                          $time, name, act.name(), exp.name()));
  endtask

  task automatic check_order(input string name, input axil_grant_e act, input axil_grant_e exp);
    if (act !== exp)
      abort_run($sformatf("Mismatch at %0t ns: %s got %s expected %s",
                          $time, name, act.name(), exp.name()));
  endtask

  task automatic check_flag(input string name, input logic act, input logic exp);
    if (act !== exp)
      abort_run($sformatf("Mismatch at %0t ns: %s got %b expected %b", $time, name, act, exp));
  endtask

  task automatic check_count(input string name, input int act, input int exp);
    if (act != exp)
      abort_run($sformatf("Mismatch at %0t ns: %s got %0d expected %0d", $time, name, act, exp));
  endtask

  function automatic logic port_arready(input int port);
    return port ? m1_arready : m0_arready;
  endfunction

  function automatic logic port_rvalid(input int port);
    return port ? m1_rvalid : m0_rvalid;
  endfunction

  function automatic logic [DATA_WIDTH-1:0] port_rdata(input int port);
    return port ? m1_rdata : m0_rdata;
  endfunction

  function automatic axil_resp_e port_rresp(input int port);
    return port ? m1_rresp : m0_rresp;
  endfunction

  function automatic int next_stall();
    return ($random(seed) & 32'h7fff_ffff) % (MAX_STALL + 1);
  endfunction

  // ----------------------------------------------------------------------
  // Bus transactions
  // ----------------------------------------------------------------------
  task automatic read_txn(input int port, input logic [ADDR_WIDTH-1:0] addr, input int stall,
                          output logic [DATA_WIDTH-1:0] data, output axil_resp_e resp);
    int    lat;
    string pn;
    pn = port ? "m1" : "m0";
    @(posedge clk);
    #2;
    if (port) begin
      m1_arvalid = 1'b1;
      m1_araddr  = addr;
      m1_rready  = (stall == 0);
    end else begin
      m0_arvalid = 1'b1;
      m0_araddr  = addr;
      m0_rready  = (stall == 0);
    end
    @(negedge clk);
    while (!port_arready(port)) @(negedge clk);
    @(posedge clk);
    #2;
    if (port) m1_arvalid = 1'b0;
    else m0_arvalid = 1'b0;
    lat = 0;
    do begin
      @(negedge clk);
      lat++;
    end while (!port_rvalid(port) && lat < 8);
    // Third negedge after the handshake follows edge A plus 2
    check_count({pn, "_rvalid latency"}, lat - 1, 2);
    data = port_rdata(port);
    resp = port_rresp(port);
    if (stall > 0) begin
      repeat (stall) begin
        @(negedge clk);
        check_flag({pn, "_rvalid held"}, port_rvalid(port), 1'b1);
        check_data({pn, "_rdata held"}, port_rdata(port), data);
        check_resp({pn, "_rresp held"}, port_rresp(port), resp);
      end
      @(posedge clk);
      #2;
      if (port) m1_rready = 1'b1;
      else m0_rready = 1'b1;
    end
    @(posedge clk);
    #2;
    if (port) m1_rready = 1'b0;
    else m0_rready = 1'b0;
    served.push_back(port ? GRANT_DATA : GRANT_FETCH);
    @(negedge clk);
    check_flag({pn, "_rvalid after handshake"}, port_rvalid(port), 1'b0);
  endtask

  task automatic write_txn(input logic [ADDR_WIDTH-1:0] addr, input logic [DATA_WIDTH-1:0] data,
                           input logic [STRB_WIDTH-1:0] strb, input int stall,
                           output axil_resp_e resp);
    @(posedge clk);
    #2;
    m1_awvalid = 1'b1;
    m1_awaddr  = addr;
    @(negedge clk);
    while (!m1_awready) @(negedge clk);
    @(posedge clk);
    #2;
    m1_awvalid = 1'b0;
    m1_wvalid  = 1'b1;
    m1_wdata   = data;
    m1_wstrb   = strb;
    @(negedge clk);
    while (!m1_wready) @(negedge clk);
    @(posedge clk);
    #2;
    m1_wvalid = 1'b0;
    @(negedge clk);
    check_flag("m1_bvalid", m1_bvalid, 1'b1);
    resp = m1_bresp;
    repeat (stall) begin
      @(negedge clk);
      check_flag("m1_bvalid held", m1_bvalid, 1'b1);
      check_resp("m1_bresp held", m1_bresp, resp);
      check_flag("m1_awready during response", m1_awready, 1'b0);
    end
    @(posedge clk);
    #2;
    m1_bready = 1'b1;
    @(posedge clk);
    #2;
    m1_bready = 1'b0;
    @(negedge clk);
    check_flag("m1_bvalid after handshake", m1_bvalid, 1'b0);
    check_flag("m1_awready after response", m1_awready, 1'b1);
  endtask

  // Reference model of the SRAM and its range rule
  function automatic axil_resp_e model_resp(input logic [ADDR_WIDTH-1:0] addr);
    return ((addr / STRB_WIDTH) >= MEM_DEPTH) ? SLVERR : OKAY;
  endfunction

  function automatic logic [DATA_WIDTH-1:0] model_read(input logic [ADDR_WIDTH-1:0] addr);
    if (model_resp(addr) == SLVERR) return '0;
    return ref_mem[int'(addr / STRB_WIDTH)];
  endfunction

  task automatic model_write(input logic [ADDR_WIDTH-1:0] addr,
                             input logic [DATA_WIDTH-1:0] data, input logic [STRB_WIDTH-1:0] strb);
    int                    idx;
    logic [DATA_WIDTH-1:0] word;
    idx  = int'(addr / STRB_WIDTH);
    word = ref_mem.exists(idx) ? ref_mem[idx] : '0;
    for (int lane = 0; lane < STRB_WIDTH; lane++) begin
      if (strb[lane]) word[8*lane +: 8] = data[8*lane +: 8];
    end
    if (model_resp(addr) == OKAY) ref_mem[idx] = word;
  endtask

  task automatic load_patterns();
    int                    fd;
    string                 line;
    byte                   op;
    int                    port;
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] data, exp;
    logic [STRB_WIDTH-1:0] strb;
    logic [1:0]            resp;
    fd = $fopen("bench/axil_mem_patterns.txt", "r");
    if (fd == 0) abort_run("Could not open the pattern file bench/axil_mem_patterns.txt");
    while ($fgets(line, fd) > 0) begin
      if (line.len() < 2 || line[0] == "#") continue;
      if ($sscanf(line, "%c %d %h %h %h %h %h", op, port, addr, data, strb, resp, exp) == 7) begin
        pat_op.push_back(op);
        pat_port.push_back(port);
        pat_addr.push_back(addr);
        pat_data.push_back(data);
        pat_strb.push_back(strb);
        pat_resp.push_back(axil_resp_e'(resp));
        pat_exp.push_back(exp);
      end
    end
    $fclose(fd);
    if (pat_op.size() == 0) abort_run("The pattern file holds no transactions");
  endtask

  // ----------------------------------------------------------------------
  // Watchdog
  // ----------------------------------------------------------------------
  initial begin
    wait (wd_limit > 0);
    repeat (wd_limit) @(posedge clk);
    abort_run($sformatf("Timeout: the run did not finish within %0d cycles", wd_limit));
  end

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------
  initial begin
    logic [DATA_WIDTH-1:0] rd0, rd1;
    axil_resp_e            rs0, rs1;
    int                    i;
    clk        = 1'b0;
    rst_n      = 1'b0;
    m0_arvalid = 1'b0;
    m0_araddr  = '0;
    m0_rready  = 1'b0;
    m1_awvalid = 1'b0;
    m1_awaddr  = '0;
    m1_wvalid  = 1'b0;
    m1_wdata   = '0;
    m1_wstrb   = '0;
    m1_bready  = 1'b0;
    m1_arvalid = 1'b0;
    m1_araddr  = '0;
    m1_rready  = 1'b0;
    load_patterns();
    wd_limit = pat_op.size() * (2 * MAX_STALL + 20) + 40;
    repeat (10) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(negedge clk);
    check_flag("m0_rvalid after reset", m0_rvalid, 1'b0);
    check_flag("m1_rvalid after reset", m1_rvalid, 1'b0);
    check_flag("m1_bvalid after reset", m1_bvalid, 1'b0);
    check_flag("m1_wready after reset", m1_wready, 1'b0);
    check_flag("m0_arready after reset", m0_arready, 1'b1);
    check_flag("m1_arready after reset", m1_arready, 1'b1);
    check_flag("m1_awready after reset", m1_awready, 1'b1);

    i = 0;
    while (i < pat_op.size()) begin
      if (pat_op[i] == "W") begin
        write_txn(pat_addr[i], pat_data[i], pat_strb[i], next_stall(), rs0);
        check_resp("m1_bresp", rs0, pat_resp[i]);
        check_resp("m1_bresp vs model", rs0, model_resp(pat_addr[i]));
        model_write(pat_addr[i], pat_data[i], pat_strb[i]);
        i++;
      end else if (pat_op[i] == "R") begin
        read_txn(pat_port[i], pat_addr[i], next_stall(), rd0, rs0);
        check_resp("rresp", rs0, pat_resp[i]);
        check_resp("rresp vs model", rs0, model_resp(pat_addr[i]));
        check_data("rdata", rd0, pat_exp[i]);
        check_data("rdata vs model", rd0, model_read(pat_addr[i]));
        i++;
      end else if (pat_op[i] == "A" && i + 1 < pat_op.size()) begin
        served.delete();
        fork
          read_txn(pat_port[i], pat_addr[i], 0, rd0, rs0);
          read_txn(pat_port[i+1], pat_addr[i+1], 0, rd1, rs1);
        join
        check_order("first served", served[0], pat_port[i] ? GRANT_DATA : GRANT_FETCH);
        check_order("second served", served[1], pat_port[i+1] ? GRANT_DATA : GRANT_FETCH);
        check_resp("rresp first", rs0, pat_resp[i]);
        check_resp("rresp second", rs1, pat_resp[i+1]);
        check_data("rdata first", rd0, pat_exp[i]);
        check_data("rdata second", rd1, pat_exp[i+1]);
        check_data("rdata first vs model", rd0, model_read(pat_addr[i]));
        check_data("rdata second vs model", rd1, model_read(pat_addr[i+1]));
        i += 2;
      end else begin
        abort_run($sformatf("Pattern line %0d has an unknown or unpaired operation", i));
      end
    end

    $display(">>> PASS");
    $finish;
  end

endmodule

/* build.f */
rtl/axil_mem_pkg.sv
rtl/axil_sram_bank.sv
rtl/axil_sram_wrap.sv
rtl/axil_read_arbiter.sv
rtl/axil_mem_top.sv
bench/axil_mem_props.sv
bench/tb_axil_mem.sv

/* rtl/axil_mem_pkg.sv */
// AXI-lite memory shared types

package axil_mem_pkg;

  // --------------------------------------------------------------------
  // Response codes
  // --------------------------------------------------------------------
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axil_resp_e;

  // --------------------------------------------------------------------
  // Owner of the shared read path
  // --------------------------------------------------------------------
  typedef enum logic {
    GRANT_FETCH = 1'b0,
    GRANT_DATA  = 1'b1
  } axil_grant_e;

  // --------------------------------------------------------------------
  // Default geometry
  // --------------------------------------------------------------------
  // Byte address width
  localparam int AXIL_ADDR_WIDTH_DEF = 32;
  // Data bus width, power of two, 8 or more
  localparam int AXIL_DATA_WIDTH_DEF = 64;
  // Memory depth in words
  localparam int AXIL_MEM_DEPTH_DEF  = 256;

endpackage

/* rtl/axil_mem_top.sv */
// Shared SRAM memory subsystem
`timescale 1ns/1ns

module axil_mem_top
  import axil_mem_pkg::*;
#(
  parameter int ADDR_WIDTH = AXIL_ADDR_WIDTH_DEF,
  parameter int DATA_WIDTH = AXIL_DATA_WIDTH_DEF,
  parameter int MEM_DEPTH  = AXIL_MEM_DEPTH_DEF
) (
  input  logic                      i_aclk,
  input  logic                      i_rst_n,
  // Port 0, fetch reads
  input  logic                      i_m0_arvalid,
  output logic                      o_m0_arready,
  input  logic [ADDR_WIDTH-1:0]     i_m0_araddr,
  output logic                      o_m0_rvalid,
  input  logic                      i_m0_rready,
  output logic [DATA_WIDTH-1:0]     o_m0_rdata,
  output axil_resp_e                o_m0_rresp,
  // Port 1, loads and stores
  input  logic                      i_m1_awvalid,
  output logic                      o_m1_awready,
  input  logic [ADDR_WIDTH-1:0]     i_m1_awaddr,
  input  logic                      i_m1_wvalid,
  output logic                      o_m1_wready,
  input  logic [DATA_WIDTH-1:0]     i_m1_wdata,
  input  logic [(DATA_WIDTH/8)-1:0] i_m1_wstrb,
  output logic                      o_m1_bvalid,
  input  logic                      i_m1_bready,
  output axil_resp_e                o_m1_bresp,
  input  logic                      i_m1_arvalid,
  output logic                      o_m1_arready,
  input  logic [ADDR_WIDTH-1:0]     i_m1_araddr,
  output logic                      o_m1_rvalid,
  input  logic                      i_m1_rready,
  output logic [DATA_WIDTH-1:0]     o_m1_rdata,
  output axil_resp_e                o_m1_rresp
);

  // Single read master seen by the slave
  logic                  s_arvalid;
  logic                  s_arready;
  logic [ADDR_WIDTH-1:0] s_araddr;
  logic                  s_rvalid;
  logic                  s_rready;
  logic [DATA_WIDTH-1:0] s_rdata;
  axil_resp_e            s_rresp;

  axil_read_arbiter #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .DATA_WIDTH (DATA_WIDTH)
  ) u_arb (
    .i_aclk       (i_aclk),
    .i_rst_n      (i_rst_n),
    .i_m0_arvalid (i_m0_arvalid),
    .o_m0_arready (o_m0_arready),
    .i_m0_araddr  (i_m0_araddr),
    .o_m0_rvalid  (o_m0_rvalid),
    .i_m0_rready  (i_m0_rready),
    .o_m0_rdata   (o_m0_rdata),
    .o_m0_rresp   (o_m0_rresp),
    .i_m1_arvalid (i_m1_arvalid),
    .o_m1_arready (o_m1_arready),
    .i_m1_araddr  (i_m1_araddr),
    .o_m1_rvalid  (o_m1_rvalid),
    .i_m1_rready  (i_m1_rready),
    .o_m1_rdata   (o_m1_rdata),
    .o_m1_rresp   (o_m1_rresp),
    .o_s_arvalid  (s_arvalid),
    .i_s_arready  (s_arready),
    .o_s_araddr   (s_araddr),
    .i_s_rvalid   (s_rvalid),
    .o_s_rready   (s_rready),
    .i_s_rdata    (s_rdata),
    .i_s_rresp    (s_rresp)
  );

  // Writes bypass the arbiter
  axil_sram_wrap #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .DATA_WIDTH (DATA_WIDTH),
    .MEM_DEPTH  (MEM_DEPTH)
  ) u_wrap (
    .i_aclk    (i_aclk),
    .i_rst_n   (i_rst_n),
    .i_awvalid (i_m1_awvalid),
    .o_awready (o_m1_awready),
    .i_awaddr  (i_m1_awaddr),
    .i_wvalid  (i_m1_wvalid),
    .o_wready  (o_m1_wready),
    .i_wdata   (i_m1_wdata),
    .i_wstrb   (i_m1_wstrb),
    .o_bvalid  (o_m1_bvalid),
    .i_bready  (i_m1_bready),
    .o_bresp   (o_m1_bresp),
    .i_arvalid (s_arvalid),
    .o_arready (s_arready),
    .i_araddr  (s_araddr),
    .o_rvalid  (s_rvalid),
    .i_rready  (s_rready),
    .o_rdata   (s_rdata),
    .o_rresp   (s_rresp)
  );

endmodule

/* rtl/axil_read_arbiter.sv */
// Round-robin read arbiter
`timescale 1ns/1ns

module axil_read_arbiter
  import axil_mem_pkg::*;
#(
  parameter int ADDR_WIDTH = AXIL_ADDR_WIDTH_DEF,
  parameter int DATA_WIDTH = AXIL_DATA_WIDTH_DEF
) (
  input  logic                  i_aclk,
  input  logic                  i_rst_n,
  // Master 0, instruction fetch
  input  logic                  i_m0_arvalid,
  output logic                  o_m0_arready,
  input  logic [ADDR_WIDTH-1:0] i_m0_araddr,
  output logic                  o_m0_rvalid,
  input  logic                  i_m0_rready,
  output logic [DATA_WIDTH-1:0] o_m0_rdata,
  output axil_resp_e            o_m0_rresp,
  // Master 1, load/store
  input  logic                  i_m1_arvalid,
  output logic                  o_m1_arready,
  input  logic [ADDR_WIDTH-1:0] i_m1_araddr,
  output logic                  o_m1_rvalid,
  input  logic                  i_m1_rready,
  output logic [DATA_WIDTH-1:0] o_m1_rdata,
  output axil_resp_e            o_m1_rresp,
  // Slave side
  output logic                  o_s_arvalid,
  input  logic                  i_s_arready,
  output logic [ADDR_WIDTH-1:0] o_s_araddr,
  input  logic                  i_s_rvalid,
  output logic                  o_s_rready,
  input  logic [DATA_WIDTH-1:0] i_s_rdata,
  input  axil_resp_e            i_s_rresp
);

  logic        busy;
  axil_grant_e grant;
  axil_grant_e last;
  axil_grant_e pick;
  logic        s_ar_fire;
  logic        s_r_fire;

  // --------------------------------------------------------------------
  // Selection while idle
  // --------------------------------------------------------------------
  // On a tie the master not served last wins
  always_comb begin
    if (i_m0_arvalid && i_m1_arvalid) begin
      pick = (last == GRANT_FETCH) ? GRANT_DATA : GRANT_FETCH;
    end else if (i_m1_arvalid) begin
      pick = GRANT_DATA;
    end else begin
      pick = GRANT_FETCH;
    end
  end

  assign o_s_arvalid = ~busy & (i_m0_arvalid | i_m1_arvalid);
  assign o_s_araddr  = (pick == GRANT_FETCH) ? i_m0_araddr : i_m1_araddr;

  // A master only loses ready when the other one is picked over it
  assign o_m0_arready = ~busy & i_s_arready & ~(i_m1_arvalid & (pick == GRANT_DATA));
  assign o_m1_arready = ~busy & i_s_arready & ~(i_m0_arvalid & (pick == GRANT_FETCH));

  assign s_ar_fire = o_s_arvalid & i_s_arready;
  assign s_r_fire  = i_s_rvalid & o_s_rready;

  // --------------------------------------------------------------------
  // Grant tracking
  // --------------------------------------------------------------------
  // Last served starts at data so fetch wins first after reset
  always_ff @(posedge i_aclk) begin
    if (!i_rst_n) begin
      busy  <= 1'b0;
      grant <= GRANT_FETCH;
      last  <= GRANT_DATA;
    end else if (!busy) begin
      if (s_ar_fire) begin
        busy  <= 1'b1;
        grant <= pick;
      end
    end else if (s_r_fire) begin
      busy <= 1'b0;
      last <= grant;
    end
  end

  // --------------------------------------------------------------------
  // Return path
  // --------------------------------------------------------------------
  assign o_m0_rvalid = busy & (grant == GRANT_FETCH) & i_s_rvalid;
  assign o_m1_rvalid = busy & (grant == GRANT_DATA) & i_s_rvalid;
  assign o_s_rready  = busy & ((grant == GRANT_FETCH) ? i_m0_rready : i_m1_rready);

  // Payload fans out, valid alone tells who owns it
  assign o_m0_rdata = i_s_rdata;
  assign o_m1_rdata = i_s_rdata;
  assign o_m0_rresp = i_s_rresp;
  assign o_m1_rresp = i_s_rresp;

endmodule

/* rtl/axil_sram_bank.sv */
// Byte-lane SRAM array
`timescale 1ns/1ns

module axil_sram_bank
  import axil_mem_pkg::*;
#(
  parameter int DATA_WIDTH = AXIL_DATA_WIDTH_DEF,
  parameter int MEM_DEPTH  = AXIL_MEM_DEPTH_DEF
) (
  input  logic                                          i_aclk,
  input  logic                                          i_en,
  input  logic                                          i_we,
  input  logic [((MEM_DEPTH > 1) ? $clog2(MEM_DEPTH) : 1)-1:0] i_idx,
  input  logic [DATA_WIDTH-1:0]                         i_wdata,
  input  logic [(DATA_WIDTH/8)-1:0]                     i_wstrb,
  output logic [DATA_WIDTH-1:0]                         o_rdata
);

  localparam int STRB_WIDTH = DATA_WIDTH / 8;

  // Word storage, contents undefined after power-up
  logic [DATA_WIDTH-1:0] mem [MEM_DEPTH];

  // --------------------------------------------------------------------
  // Write port, one byte lane per strobe bit
  // --------------------------------------------------------------------
  always_ff @(posedge i_aclk) begin
    if (i_en && i_we) begin
      for (int lane = 0; lane < STRB_WIDTH; lane++) begin
        if (i_wstrb[lane]) begin
          mem[i_idx][8*lane +: 8] <= i_wdata[8*lane +: 8];
        end
      end
    end
  end

  // --------------------------------------------------------------------
  // Read port
  // --------------------------------------------------------------------
  // Output only moves on an enabled read, so it holds across writes
  always_ff @(posedge i_aclk) begin
    if (i_en && !i_we) begin
      o_rdata <= mem[i_idx];
    end
  end

endmodule

/* rtl/axil_sram_wrap.sv */
// AXI-lite SRAM slave
`timescale 1ns/1ns

module axil_sram_wrap
  import axil_mem_pkg::*;
#(
  parameter int ADDR_WIDTH = AXIL_ADDR_WIDTH_DEF,
  parameter int DATA_WIDTH = AXIL_DATA_WIDTH_DEF,
  parameter int MEM_DEPTH  = AXIL_MEM_DEPTH_DEF
) (
  input  logic                      i_aclk,
  input  logic                      i_rst_n,
  // Write address channel
  input  logic                      i_awvalid,
  output logic                      o_awready,
  input  logic [ADDR_WIDTH-1:0]     i_awaddr,
  // Write data channel
  input  logic                      i_wvalid,
  output logic                      o_wready,
  input  logic [DATA_WIDTH-1:0]     i_wdata,
  input  logic [(DATA_WIDTH/8)-1:0] i_wstrb,
  // Write response channel
  output logic                      o_bvalid,
  input  logic                      i_bready,
  output axil_resp_e                o_bresp,
  // Read address channel
  input  logic                      i_arvalid,
  output logic                      o_arready,
  input  logic [ADDR_WIDTH-1:0]     i_araddr,
  // Read data channel
  output logic                      o_rvalid,
  input  logic                      i_rready,
  output logic [DATA_WIDTH-1:0]     o_rdata,
  output axil_resp_e                o_rresp
);

  localparam int STRB_WIDTH = DATA_WIDTH / 8;
  localparam int OFFS_W     = $clog2(STRB_WIDTH);
  localparam int WORD_W     = ADDR_WIDTH - OFFS_W;
  localparam int IDX_W      = (MEM_DEPTH > 1) ? $clog2(MEM_DEPTH) : 1;
  // One spare bit so a depth of exactly 2**WORD_W still compares right
  localparam logic [WORD_W:0] DEPTH_LIM = (WORD_W + 1)'(MEM_DEPTH);

  typedef enum logic {RD_IDLE, RD_READ} rd_state_e;
  typedef enum logic [1:0] {WR_IDLE, WR_WRITE, WR_RESP} wr_state_e;

  rd_state_e             rd_state;
  wr_state_e             wr_state;
  logic                  aw_fire, w_fire, b_fire, ar_fire, r_fire;
  logic                  rd_fetch, rd_stage;
  logic [IDX_W-1:0]      rd_idx, wr_idx;
  logic                  rd_err, wr_err;
  logic                  wr_commit;
  logic                  bank_en;
  logic [IDX_W-1:0]      bank_idx;
  logic [DATA_WIDTH-1:0] bank_rdata;

  function automatic logic out_of_range(input logic [ADDR_WIDTH-1:0] addr);
    return {1'b0, addr[ADDR_WIDTH-1:OFFS_W]} >= DEPTH_LIM;
  endfunction

  function automatic logic [IDX_W-1:0] word_idx(input logic [ADDR_WIDTH-1:0] addr);
    return addr[OFFS_W +: IDX_W];
  endfunction

  assign aw_fire = i_awvalid & o_awready;
  assign w_fire  = i_wvalid  & o_wready;
  assign b_fire  = o_bvalid  & i_bready;
  assign ar_fire = i_arvalid & o_arready;
  assign r_fire  = o_rvalid  & i_rready;

  // --------------------------------------------------------------------
  // Read side
  // --------------------------------------------------------------------
  // rd_fetch marks the bank access cycle, rd_stage the output load
  always_ff @(posedge i_aclk) begin
    if (!i_rst_n) begin
      rd_state <= RD_IDLE;
      rd_fetch <= 1'b0;
      rd_stage <= 1'b0;
      o_rvalid <= 1'b0;
    end else begin
      rd_fetch <= ar_fire;
      rd_stage <= rd_fetch;
      case (rd_state)
        RD_IDLE: if (ar_fire) rd_state <= RD_READ;
        RD_READ: if (r_fire) rd_state <= RD_IDLE;
        default: rd_state <= RD_IDLE;
      endcase
      if (r_fire) begin
        o_rvalid <= 1'b0;
      end else if (rd_stage) begin
        o_rvalid <= 1'b1;
      end
    end
  end

  always_ff @(posedge i_aclk) begin
    if (ar_fire) begin
      rd_idx <= word_idx(i_araddr);
      rd_err <= out_of_range(i_araddr);
    end
    if (rd_stage) begin
      o_rdata <= rd_err ? '0 : bank_rdata;
      o_rresp <= rd_err ? SLVERR : OKAY;
    end
  end

  assign o_arready = (rd_state == RD_IDLE);

  // --------------------------------------------------------------------
  // Write side
  // --------------------------------------------------------------------
  always_ff @(posedge i_aclk) begin
    if (!i_rst_n) begin
      wr_state <= WR_IDLE;
      o_bvalid <= 1'b0;
    end else begin
      case (wr_state)
        WR_IDLE:  if (aw_fire) wr_state <= WR_WRITE;
        WR_WRITE: if (w_fire) wr_state <= WR_RESP;
        WR_RESP:  if (b_fire) wr_state <= WR_IDLE;
        default:  wr_state <= WR_IDLE;
      endcase
      if (b_fire) begin
        o_bvalid <= 1'b0;
      end else if (w_fire) begin
        o_bvalid <= 1'b1;
      end
    end
  end

  // Address is latched at its handshake, not tracked afterwards
  always_ff @(posedge i_aclk) begin
    if (aw_fire) begin
      wr_idx <= word_idx(i_awaddr);
      wr_err <= out_of_range(i_awaddr);
    end
    if (w_fire) begin
      o_bresp <= wr_err ? SLVERR : OKAY;
    end
  end

  assign o_awready = (wr_state == WR_IDLE);
  // Single bank port, the read fetch owns it for its one cycle
  assign o_wready  = (wr_state == WR_WRITE) & ~rd_fetch;
  assign wr_commit = w_fire & ~wr_err;

  // --------------------------------------------------------------------
  // Memory bank
  // --------------------------------------------------------------------
  assign bank_en  = rd_fetch | wr_commit;
  assign bank_idx = rd_fetch ? rd_idx : wr_idx;

  axil_sram_bank #(
    .DATA_WIDTH (DATA_WIDTH),
    .MEM_DEPTH  (MEM_DEPTH)
  ) u_bank (
    .i_aclk  (i_aclk),
    .i_en    (bank_en),
    .i_we    (wr_commit),
    .i_idx   (bank_idx),
    .i_wdata (i_wdata),
    .i_wstrb (i_wstrb),
    .o_rdata (bank_rdata)
  );

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build and run the memory subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_axil_mem \
  -f build.f \
  -o sim_tb \
  || { echo "Verilator build failed"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1 || echo "Simulator returned a failing status"

cat sim.log

grep -q '>>> FAIL' sim.log && exit 1 || grep -q '>>> PASS' sim.log && exit 0 || exit 1
